// ==== mips_decode.f ====
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/main_decoder.sv
source/reg_file.sv
source/operand_stage.sv
source/mips_decode.sv
test/tb_mips_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_mips_decode -f mips_decode.f &&
./obj_dir/Vtb_mips_decode > sim.log 2>&1
grep -qs "Done: no errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== source/main_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module main_decoder (
    input  mips_isa_pkg::instr_u      instr,
    output mips_isa_pkg::decoded_op_t op,
    output logic                      exception_ri,
    output mips_ctrl_pkg::control_t   ctl
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic is_rtype;

    assign is_rtype = (instr.r_fields.op == OP_RT);

    always_comb begin
        op = RESERVED; // anything not matched below stays reserved
        case (instr.r_fields.op)
            OP_RT: begin
                case (instr.r_fields.funct)
                    F_ADD: op = ADD;
                    F_ADDU: op = ADDU;
                    F_SUB: op = SUB;
                    F_SUBU: op = SUBU;
                    F_SLT: op = SLT;
                    F_SLTU: op = SLTU;
                    F_AND: op = AND;
                    F_OR: op = OR;
                    F_XOR: op = XOR;
                    F_NOR: op = NOR;
                    F_SLL: op = SLL;
                    F_SRL: op = SRL;
                    F_SRA: op = SRA;
                    F_SLLV: op = SLLV;
                    F_SRLV: op = SRLV;
                    F_SRAV: op = SRAV;
                    F_MULT: op = MULT;
                    F_MULTU: op = MULTU;
                    F_DIV: op = DIV;
                    F_DIVU: op = DIVU;
                    F_MFHI: op = MFHI;
                    F_MFLO: op = MFLO;
                    F_MTHI: op = MTHI;
                    F_MTLO: op = MTLO;
                    F_JR: op = JR;
                    F_JALR: op = JALR;
                    F_BREAK: op = BREAK;
                    F_SYSCALL: op = SYSCALL;
                endcase
            end
            OP_REGIMM: begin
                case (instr.i_fields.rt)
                    B_BGEZ: op = BGEZ;
                    B_BLTZ: op = BLTZ;
                    B_BGEZAL: op = BGEZAL;
                    B_BLTZAL: op = BLTZAL;
                endcase
            end
            OP_COP0: begin
                case (instr.r_fields.rs)
                    C_ERET: op = ERET;
                    C_MFC0: op = MFC0;
                    C_MTC0: op = MTC0;
                endcase
            end
            OP_ADDI: op = ADD;
            OP_ADDIU: op = ADDU;
            OP_SLTI: op = SLT;
            OP_SLTIU: op = SLTU;
            OP_ANDI: op = AND;
            OP_ORI: op = OR;
            OP_XORI: op = XOR;
            OP_LUI: op = LUI;
            OP_BEQ: op = BEQ;
            OP_BNE: op = BNE;
            OP_BGTZ: op = BGTZ;
            OP_BLEZ: op = BLEZ;
            OP_J: op = J;
            OP_JAL: op = JAL;
            OP_LB: op = LB;
            OP_LBU: op = LBU;
            OP_LH: op = LH;
            OP_LHU: op = LHU;
            OP_LW: op = LW;
            OP_SB: op = SB;
            OP_SH: op = SH;
            OP_SW: op = SW;
        endcase
    end

    always_comb begin
        ctl = '0;
        exception_ri = 1'b0;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR: begin
                ctl.regwrite = 1'b1;
                ctl.alusrc = is_rtype ? REG : IMM;
                ctl.regdst = is_rtype ? RD : RT;
                ctl.zeroext = !is_rtype && (op inside {AND, OR, XOR}); // logical immediates
            end
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                ctl.regwrite = 1'b1;
                ctl.regdst = RD;
                ctl.shift = 1'b1;
                ctl.alusrc = (op inside {SLL, SRL, SRA}) ? SHAMT : REG;
            end
            LUI: begin
                ctl.regwrite = 1'b1;
                ctl.alusrc = IMM;
                ctl.shift = 1'b1; // the ALU shifts the immediate up by 16
            end
            MULT, MULTU, DIV, DIVU: begin
                ctl.hiwrite = 1'b1;
                ctl.lowrite = 1'b1;
            end
            MTHI: ctl.hiwrite = 1'b1;
            MTLO: ctl.lowrite = 1'b1;
            MFHI, MFLO: begin
                ctl.regwrite = 1'b1;
                ctl.regdst = RD;
            end
            BEQ, BNE: begin
                ctl.branch = 1'b1;
                ctl.branch2 = 1'b1;
            end
            BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ: begin
                ctl.branch = 1'b1;
                ctl.branch1 = 1'b1;
                ctl.regwrite = (op inside {BGEZAL, BLTZAL}); // link into r31
            end
            J, JAL: begin
                ctl.jump = 1'b1;
                ctl.regwrite = (op == JAL);
            end
            JR, JALR: begin
                ctl.jump = 1'b1;
                ctl.jr = 1'b1;
                ctl.regdst = RD;
                ctl.regwrite = (op == JALR);
            end
            LB, LBU, LH, LHU, LW: begin
                ctl.regwrite = 1'b1;
                ctl.memread = 1'b1;
                ctl.alusrc = IMM;
            end
            SB, SH, SW: begin
                ctl.memwrite = 1'b1;
                ctl.alusrc = IMM;
            end
            ERET: ctl.is_eret = 1'b1;
            MFC0: ctl.regwrite = 1'b1;
            MTC0: ctl.cp0write = 1'b1;
            BREAK: ctl.is_bp = 1'b1;
            SYSCALL: ctl.is_sys = 1'b1;
            default: exception_ri = 1'b1;
        endcase

        case (op)
            ADD: ctl.alufunc = ALU_ADD;
            ADDU, LB, LBU, LH, LHU, LW, SB, SH, SW: ctl.alufunc = ALU_ADDU; // address add
            SUB: ctl.alufunc = ALU_SUB;
            SUBU: ctl.alufunc = ALU_SUBU;
            SLT: ctl.alufunc = ALU_SLT;
            SLTU: ctl.alufunc = ALU_SLTU;
            AND: ctl.alufunc = ALU_AND;
            OR: ctl.alufunc = ALU_OR;
            NOR: ctl.alufunc = ALU_NOR;
            XOR: ctl.alufunc = ALU_XOR;
            SLL, SLLV, LUI: ctl.alufunc = ALU_SLL;
            SRL, SRLV: ctl.alufunc = ALU_SRL;
            SRA, SRAV: ctl.alufunc = ALU_SRA;
            default: ctl.alufunc = ALU_PASSA;
        endcase

        case (op)
            BNE: ctl.branch_type = T_BNE;
            BGEZ, BGEZAL: ctl.branch_type = T_BGEZ;
            BLTZ, BLTZAL: ctl.branch_type = T_BLTZ;
            BGTZ: ctl.branch_type = T_BGTZ;
            BLEZ: ctl.branch_type = T_BLEZ;
            default: ctl.branch_type = T_BEQ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mips_ctrl_pkg.sv ====
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSA
    } alufunc_t;

    typedef enum logic [1:0] {REG, IMM, SHAMT} alusrc_t;
    typedef enum logic {RT, RD} regdst_t;
    typedef enum logic [2:0] {T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ} branch_type_t;

    typedef struct packed {
        alufunc_t     alufunc;
        alusrc_t      alusrc;
        regdst_t      regdst;
        branch_type_t branch_type;
        logic         regwrite;
        logic         memread;
        logic         memwrite;
        logic         branch;
        logic         branch1; // compares rs against zero
        logic         branch2; // compares rs against rt
        logic         jump;
        logic         jr;
        logic         shift;
        logic         zeroext;
        logic         hiwrite;
        logic         lowrite;
        logic         cp0write;
        logic         is_eret;
        logic         is_bp;
        logic         is_sys;
    } control_t;

    typedef struct packed {
        logic                    en;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } wb_t;

    typedef struct packed {
        logic                      valid;
        mips_isa_pkg::decoded_op_t op;
        control_t                  ctl;
        logic                      exception_ri;
        mips_isa_pkg::word_t       rs_val;
        mips_isa_pkg::word_t       rt_val;
        mips_isa_pkg::word_t       imm_ext;
        logic [4:0]                shamt;
        mips_isa_pkg::reg_addr_t   dst;
    } decode_out_t;

endpackage

`default_nettype wire

// ==== source/mips_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_decode #(
    parameter int NREGS = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mips_isa_pkg::instr_u       instr,
    input  logic                       instr_valid,
    input  logic                       stall,       // level from hazard logic
    input  logic                       flush,       // pulse from branch resolution
    input  mips_ctrl_pkg::wb_t         wb,
    output mips_ctrl_pkg::decode_out_t de
);

    operand_stage #(.NREGS(NREGS)) u_operand (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .wb          (wb),
        .de          (de)
    );

endmodule

`default_nettype wire

// ==== source/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    // primary opcodes, bits 31:26
    localparam op_t OP_RT = 6'b000000, OP_REGIMM = 6'b000001, OP_COP0 = 6'b010000;
    localparam op_t OP_J = 6'b000010, OP_JAL = 6'b000011;
    localparam op_t OP_BEQ = 6'b000100, OP_BNE = 6'b000101;
    localparam op_t OP_BLEZ = 6'b000110, OP_BGTZ = 6'b000111;
    localparam op_t OP_ADDI = 6'b001000, OP_ADDIU = 6'b001001;
    localparam op_t OP_SLTI = 6'b001010, OP_SLTIU = 6'b001011;
    localparam op_t OP_ANDI = 6'b001100, OP_ORI = 6'b001101;
    localparam op_t OP_XORI = 6'b001110, OP_LUI = 6'b001111;
    localparam op_t OP_LB = 6'b100000, OP_LH = 6'b100001, OP_LW = 6'b100011;
    localparam op_t OP_LBU = 6'b100100, OP_LHU = 6'b100101;
    localparam op_t OP_SB = 6'b101000, OP_SH = 6'b101001, OP_SW = 6'b101011;

    // funct field of SPECIAL, bits 5:0
    localparam func_t F_SLL = 6'b000000, F_SRL = 6'b000010, F_SRA = 6'b000011;
    localparam func_t F_SLLV = 6'b000100, F_SRLV = 6'b000110, F_SRAV = 6'b000111;
    localparam func_t F_JR = 6'b001000, F_JALR = 6'b001001;
    localparam func_t F_SYSCALL = 6'b001100, F_BREAK = 6'b001101;
    localparam func_t F_MFHI = 6'b010000, F_MTHI = 6'b010001;
    localparam func_t F_MFLO = 6'b010010, F_MTLO = 6'b010011;
    localparam func_t F_MULT = 6'b011000, F_MULTU = 6'b011001;
    localparam func_t F_DIV = 6'b011010, F_DIVU = 6'b011011;
    localparam func_t F_ADD = 6'b100000, F_ADDU = 6'b100001;
    localparam func_t F_SUB = 6'b100010, F_SUBU = 6'b100011;
    localparam func_t F_AND = 6'b100100, F_OR = 6'b100101;
    localparam func_t F_XOR = 6'b100110, F_NOR = 6'b100111;
    localparam func_t F_SLT = 6'b101010, F_SLTU = 6'b101011;

    localparam reg_addr_t B_BLTZ = 5'b00000, B_BGEZ = 5'b00001; // REGIMM selects on rt
    localparam reg_addr_t B_BLTZAL = 5'b10000, B_BGEZAL = 5'b10001;
    localparam reg_addr_t C_MFC0 = 5'b00000, C_MTC0 = 5'b00100; // COP0 selects on rs
    localparam reg_addr_t C_ERET = 5'b10000;

    typedef struct packed {
        op_t       op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        func_t     funct;
    } r_fields_t;

    typedef struct packed {
        op_t         op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
        SLL, SRL, SRA, SLLV, SRLV, SRAV, MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO, BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL,
        BGTZ, BLEZ, J, JAL, JR, JALR, LB, LBU, LH, LHU, LW, SB, SH, SW,
        ERET, MFC0, MTC0, BREAK, SYSCALL, RESERVED
    } decoded_op_t;

endpackage

`default_nettype wire

// ==== source/operand_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_stage #(
    parameter int NREGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mips_isa_pkg::instr_u         instr,
    input  logic                         instr_valid,
    input  logic                         stall,
    input  logic                         flush,
    input  mips_ctrl_pkg::wb_t           wb,
    output mips_ctrl_pkg::decode_out_t   de
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    decoded_op_t op;
    logic        exception_ri;
    control_t    ctl;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm_ext;
    reg_addr_t   dst;
    decode_out_t d_next;

    main_decoder u_dec (
        .instr        (instr),
        .op           (op),
        .exception_ri (exception_ri),
        .ctl          (ctl)
    );

    reg_file #(.NREGS(NREGS)) u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (instr.r_fields.rs),
        .rt_addr (instr.r_fields.rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wb      (wb)
    );

    assign imm_ext = ctl.zeroext ? {16'h0000, instr.i_fields.imm}
                                 : {{16{instr.i_fields.imm[15]}}, instr.i_fields.imm};

    always_comb begin
        if (op inside {JAL, BGEZAL, BLTZAL}) begin
            dst = 5'd31; // link register
        end else if (ctl.regdst == RD) begin
            dst = instr.r_fields.rd;
        end else begin
            dst = instr.r_fields.rt;
        end
    end

    always_comb begin
        d_next.valid = instr_valid;
        d_next.op = op;
        d_next.ctl = ctl;
        d_next.exception_ri = exception_ri;
        d_next.rs_val = rs_val;
        d_next.rt_val = rt_val;
        d_next.imm_ext = imm_ext;
        d_next.shamt = instr.r_fields.shamt;
        d_next.dst = dst;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin // flush beats stall
            de.valid <= 1'b0;
            de.ctl <= '0;
            de.exception_ri <= 1'b0;
        end else if (!stall) begin
            de <= d_next;
        end
    end

    a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !de.valid);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int NREGS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    output mips_isa_pkg::word_t     rs_val,
    output mips_isa_pkg::word_t     rt_val,
    input  mips_ctrl_pkg::wb_t      wb
);
    import mips_isa_pkg::*;

    word_t regs [NREGS];

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) return '0; // r0 is hardwired to zero
        if (wb.en && wb.addr == addr) return wb.data; // writeback in flight wins
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

    // writeback must stay inside the configured register count
    a_wb_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        wb.en |-> (int'(wb.addr) < NREGS));

endmodule

`default_nettype wire

// ==== test/decode_stimulus.txt ====
# W reg (data from the LFSR) | D instr_hex op ctl_hex exception_ri | S cycles | F stall_level
# a W record shares the cycle of the record after it
W 5
D 00000000 SLL 2a88080 0
W 6
D 00a63820 ADD 88000 0
S 3
D 20a4fff0 ADD 108000 0
F 1
D 30c88001 AND 1908040 0
W 0
D 380affff XOR 2508040 0
D 34a99abc OR 1d08040 0
D 28cb8000 SLT 1108000 0
D 8cacfffc LW 50c000 0
D aca60008 SW 502000 0
D 10a60004 BEQ 3401400 0
S 2
D 04b10010 BGEZAL 3429800 0
D 04c0fffe BLTZ 3431800 0
D 0c000040 JAL 3408200 0
F 0
D 00a00008 JR 3480300 0
D 42000018 ERET 3400004 0
D 40866000 MTC0 3400008 0
D 00067142 SRL 2e88080 0
D 3c0f1234 LUI 2908080 0
D 6c000000 RESERVED 3400000 1
D 00000001 RESERVED 3400000 1
D 04a20000 RESERVED 3400000 1
D 40200000 RESERVED 3400000 1

// ==== test/tb_mips_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_decode;
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic        clk;
    logic        rst_n;
    instr_u      instr;
    logic        instr_valid;
    logic        stall;
    logic        flush;
    wb_t         wb;
    decode_out_t de;

    word_t       ref_regs [32]; // mirror of what the register file should hold
    logic [31:0] lfsr;
    int          cycles = 0;
    int          limit = 0;

    byte         rec_kind [$];
    word_t       rec_arg [$]; // register, instruction, stall cycles or stall level
    decoded_op_t rec_op [$];
    control_t    rec_ctl [$];
    logic        rec_ri [$];

    mips_decode #(.NREGS(32)) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .wb          (wb),
        .de          (de)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the test did not finish within %0d cycles", limit);
            fail_stop();
        end
    end

    task automatic fail_stop();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_op(string what, decoded_op_t got, decoded_op_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %s, expected %s",
                     $time, what, got.name(), exp.name());
            fail_stop();
        end
    endtask

    task automatic check_ctl(string what, control_t got, control_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_addr(string what, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_word(output word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        wb.en = 1'b0; // a writeback lasts a single cycle
    endtask

    task automatic lookup_op(string name, output decoded_op_t e);
        logic        found;
        decoded_op_t cand;
        found = 1'b0;
        e = RESERVED;
        for (int k = 0; k <= int'(RESERVED); k++) begin
            cand = decoded_op_t'(k);
            if (cand.name() == name) begin
                e = cand;
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("the stimulus file names an unknown op %s", name);
            fail_stop();
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        int          ri;
        string       tok;
        string       opname;
        string       rest;
        logic [31:0] arg;
        logic [31:0] ctl_raw;
        decoded_op_t found_op;
        fd = $fopen("test/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open test/decode_stimulus.txt");
            fail_stop();
        end else begin
            while ($fscanf(fd, " %s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    found_op = RESERVED;
                    ctl_raw = '0;
                    ri = 0;
                    if (tok == "D") begin
                        n = $fscanf(fd, " %h %s %h %d", arg, opname, ctl_raw, ri);
                        if (n != 4) begin
                            $display("the stimulus file has an incomplete D record");
                            fail_stop();
                        end
                        lookup_op(opname, found_op);
                    end else begin
                        n = $fscanf(fd, " %d", arg);
                        if (n != 1) begin
                            $display("the stimulus file has an incomplete %s record", tok);
                            fail_stop();
                        end
                    end
                    rec_kind.push_back(tok[0]);
                    rec_arg.push_back(arg);
                    rec_op.push_back(found_op);
                    rec_ctl.push_back(ctl_raw[$bits(control_t)-1:0]);
                    rec_ri.push_back(ri != 0);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_decode(instr_u ir, decoded_op_t exp_op, control_t exp_ctl,
                                logic exp_ri);
        word_t     exp_imm;
        reg_addr_t exp_dst;
        if (ir.i_fields.op inside {OP_ANDI, OP_ORI, OP_XORI}) begin
            exp_imm = {16'h0000, ir.i_fields.imm}; // logical immediates
        end else begin
            exp_imm = {{16{ir.i_fields.imm[15]}}, ir.i_fields.imm};
        end
        if (exp_op inside {JAL, BGEZAL, BLTZAL}) begin
            exp_dst = 5'd31;
        end else if (exp_ctl.regdst == RD) begin
            exp_dst = ir.r_fields.rd;
        end else begin
            exp_dst = ir.r_fields.rt;
        end
        check_bit("valid", de.valid, 1'b1);
        check_op("op", de.op, exp_op);
        check_ctl("ctl", de.ctl, exp_ctl);
        check_bit("exception_ri", de.exception_ri, exp_ri);
        check_word("rs_val", de.rs_val, ref_regs[ir.r_fields.rs]);
        check_word("rt_val", de.rt_val, ref_regs[ir.r_fields.rt]);
        check_word("imm_ext", de.imm_ext, exp_imm);
        check_addr("shamt", de.shamt, ir.r_fields.shamt);
        check_addr("dst", de.dst, exp_dst);
    endtask

    task automatic check_held(decode_out_t snap);
        check_bit("held valid", de.valid, snap.valid);
        check_op("held op", de.op, snap.op);
        check_ctl("held ctl", de.ctl, snap.ctl);
        check_bit("held exception_ri", de.exception_ri, snap.exception_ri);
        check_word("held rs_val", de.rs_val, snap.rs_val);
        check_word("held rt_val", de.rt_val, snap.rt_val);
        check_word("held imm_ext", de.imm_ext, snap.imm_ext);
        check_addr("held shamt", de.shamt, snap.shamt);
        check_addr("held dst", de.dst, snap.dst);
    endtask

    task automatic check_bubble(string when);
        check_bit({"valid ", when}, de.valid, 1'b0);
        check_bit({"regwrite ", when}, de.ctl.regwrite, 1'b0);
        check_bit({"memread ", when}, de.ctl.memread, 1'b0);
        check_bit({"memwrite ", when}, de.ctl.memwrite, 1'b0);
    endtask

    initial begin
        word_t       data;
        decode_out_t held;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb = '0;
        lfsr = 32'hf8e4;
        foreach (ref_regs[r]) ref_regs[r] = '0;
        read_stimulus();
        limit = 4 * rec_kind.size() + 20;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bubble("after reset");
        foreach (rec_kind[i]) begin
            case (rec_kind[i])
                "W": begin // rides along with the next record's cycle
                    next_word(data);
                    wb.en = 1'b1;
                    wb.addr = rec_arg[i][4:0];
                    wb.data = data;
                    if (wb.addr != '0) ref_regs[wb.addr] = data;
                end
                "D": begin
                    instr = rec_arg[i];
                    instr_valid = 1'b1;
                    step();
                    check_decode(rec_arg[i], rec_op[i], rec_ctl[i], rec_ri[i]);
                end
                "S": begin
                    held = de;
                    instr = ~instr; // upstream changes must not leak through
                    stall = 1'b1;
                    repeat (rec_arg[i]) begin
                        step();
                        check_held(held);
                    end
                    stall = 1'b0;
                end
                "F": begin
                    flush = 1'b1;
                    stall = rec_arg[i][0];
                    instr_valid = 1'b1;
                    step();
                    check_bubble("after flush");
                    flush = 1'b0;
                    stall = 1'b0;
                    instr_valid = 1'b0;
                    step();
                    check_bit("valid with instr_valid low", de.valid, 1'b0);
                end
                default: begin
                    $display("the stimulus file holds an unknown record kind %c", rec_kind[i]);
                    fail_stop();
                end
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
